/* hw/uart_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart package
// baud, frame and transmit queue constants, FSM state types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uart_pkg;

  // clk cycles per bit time
  localparam int CLKS_PER_BIT = 16;
  localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);  // bit-time counter width

  localparam int DATA_BITS = 8;  // 8N1 frame
  localparam int BIT_IDX_W = $clog2(DATA_BITS);

  // transmit queue
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;  // log2 of FIFO_DEPTH

  // transmitter FSM
  typedef enum logic [2:0] {
    tx_idle,
    tx_start_bit,
    tx_data_bits,
    tx_stop_bit,
    tx_wait_go_low
  } tx_state_e;

  // receiver FSM
  typedef enum logic [1:0] {
    rx_idle,
    rx_start_bit,
    rx_data_bits,
    rx_stop_bit
  } rx_state_e;

endpackage

`default_nettype wire

/* hw/tx_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit queue
// valid/ready byte input, head byte handed on with go/bsy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tx_fifo
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,

  input  wire  [7:0] in_data,
  input  wire        in_valid,
  output logic       in_ready,

  output logic       go,       // head byte waiting to be sent
  input  wire        bsy,      // transmitter busy with the head byte
  output logic [7:0] tx_byte   // head byte, stable until retired
);

  logic [7:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;    // one extra bit to hold FIFO_DEPTH

  logic bsy_q;      // previous bsy for edge detect
  logic go_hold;    // forces go low for one cycle after a pop
  logic bsy_fall;
  logic push;
  logic pop;

  assign in_ready = (count != (FIFO_AW+1)'(FIFO_DEPTH));
  assign push     = in_valid && in_ready;

  // frame finished when bsy drops, the head is then retired
  assign bsy_fall = bsy_q && !bsy;
  assign pop      = bsy_fall && (count != '0);

  // go stays low for a cycle after each pop so the transmitter
  // sees the acknowledge and returns to idle
  assign go      = (count != '0) && !go_hold;
  assign tx_byte = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      bsy_q   <= 1'b0;
      go_hold <= 1'b0;
    end else begin
      bsy_q   <= bsy;
      go_hold <= pop;

      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart transmitter
// shifts out 8N1 frames, started by go and acknowledged by go low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,

  input  wire  [7:0] tx_byte,  // byte to send, held while go is high
  input  wire        go,       // start request, dropped once bsy has fallen

  output logic       bsy,      // high from start bit to end of stop bit
  output logic       tx_line   // serial output, idles high
);

  localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_IDX_W-1:0] IDX_LAST = BIT_IDX_W'(DATA_BITS - 1);

  tx_state_e            state;
  logic [BIT_CNT_W-1:0] bit_timer;  // cycles left in the current bit
  logic [BIT_IDX_W-1:0] bit_idx;    // data bit now on the line

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= tx_idle;
      bit_timer <= '0;
      bit_idx   <= '0;
      tx_line   <= 1'b1;
      bsy       <= 1'b0;
    end else begin
      unique case (state)

        tx_idle: begin
          if (go) begin
            // first cycle of the start bit goes out on this edge
            tx_line   <= 1'b0;
            bsy       <= 1'b1;
            bit_timer <= BIT_LAST;
            state     <= tx_start_bit;
          end
        end

        tx_start_bit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            tx_line   <= tx_byte[0];  // lsb first
            bit_idx   <= '0;
            bit_timer <= BIT_LAST;
            state     <= tx_data_bits;
          end
        end

        tx_data_bits: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            bit_timer <= BIT_LAST;
            if (bit_idx == IDX_LAST) begin
              tx_line <= 1'b1;  // stop bit
              bit_idx <= '0;
              state   <= tx_stop_bit;
            end else begin
              tx_line <= tx_byte[bit_idx + 1'b1];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end

        tx_stop_bit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            // line stays high, frame is complete
            bsy   <= 1'b0;
            state <= tx_wait_go_low;
          end
        end

        tx_wait_go_low: begin
          // the queue drops go once it has retired the byte
          if (!go) begin
            state <= tx_idle;
          end
        end

        default: begin
          state   <= tx_idle;
          tx_line <= 1'b1;
          bsy     <= 1'b0;
        end

      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart receiver
// mid-bit sampling of 8N1 frames into a valid/ready holding reg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,

  input  wire        rx_line,       // asynchronous serial input

  output logic [7:0] rx_data,
  output logic       rx_valid,
  input  wire        rx_ready,

  output logic       rx_frame_err,  // one-cycle pulse, stop bit was low
  output logic       rx_overrun     // one-cycle pulse, new byte dropped
);

  localparam logic [BIT_CNT_W-1:0] BIT_LAST  = BIT_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_LAST = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [BIT_IDX_W-1:0] IDX_LAST  = BIT_IDX_W'(DATA_BITS - 1);

  logic rx_meta;   // first synchronizer stage
  logic rx_sync;   // second stage, safe to use
  logic rx_prev;   // delayed copy for edge detect

  rx_state_e            state;
  logic [BIT_CNT_W-1:0] bit_timer;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic [7:0]           shift_reg;

  logic start_edge;
  logic hold_full;

  assign start_edge = rx_prev && !rx_sync;
  assign hold_full  = rx_valid && !rx_ready;  // byte not taken this cycle

  // line idles high, so the flops reset to 1 to avoid a false start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_line;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= rx_idle;
      bit_timer    <= '0;
      bit_idx      <= '0;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
      rx_overrun   <= 1'b0;
    end else begin
      rx_frame_err <= 1'b0;
      rx_overrun   <= 1'b0;
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;  // consumer took the byte
      end

      unique case (state)

        rx_idle: begin
          if (start_edge) begin
            bit_timer <= HALF_LAST;  // go to the middle of the start bit
            state     <= rx_start_bit;
          end
        end

        rx_start_bit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            if (!rx_sync) begin
              bit_timer <= BIT_LAST;
              bit_idx   <= '0;
              state     <= rx_data_bits;
            end else begin
              state <= rx_idle;  // glitch, not a real start bit
            end
          end
        end

        rx_data_bits: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            bit_timer <= BIT_LAST;
            bit_idx   <= bit_idx + 1'b1;
            if (bit_idx == IDX_LAST) begin
              state <= rx_stop_bit;
            end
          end
        end

        rx_stop_bit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            rx_frame_err <= !rx_sync;
            if (hold_full) begin
              rx_overrun <= 1'b1;  // keep the older byte
            end else begin
              rx_valid <= 1'b1;  // delivered even with a bad stop bit
            end
            state <= rx_idle;
          end
        end

        default: state <= rx_idle;

      endcase
    end
  end

  // data path, lsb arrives first and ends up in bit 0
  always_ff @(posedge clk) begin
    if (state == rx_data_bits && bit_timer == '0) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
    if (state == rx_stop_bit && bit_timer == '0 && !hold_full) begin
      rx_data <= shift_reg;
    end
  end

endmodule

`default_nettype wire

/* hw/uart_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart subsystem
// transmit queue and transmitter, plus the frame receiver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uart_top (
  input  wire        clk,
  input  wire        rst_n,

  // transmit byte input
  input  wire  [7:0] in_data,
  input  wire        in_valid,
  output wire        in_ready,

  // serial lines
  output wire        tx_line,
  input  wire        rx_line,

  // receive byte output
  output wire  [7:0] rx_data,
  output wire        rx_valid,
  input  wire        rx_ready,

  // status
  output wire        tx_busy,
  output wire        rx_frame_err,
  output wire        rx_overrun
);

  // go/bsy link between queue and transmitter
  wire       go;
  wire       bsy;
  wire [7:0] tx_byte;

  assign tx_busy = bsy;

  tx_fifo u_tx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .go       (go),
    .bsy      (bsy),
    .tx_byte  (tx_byte)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .go      (go),
    .bsy     (bsy),
    .tx_line (tx_line)
  );

  uart_rx u_uart_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_line      (rx_line),   // synchronized inside
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .rx_frame_err (rx_frame_err),
    .rx_overrun   (rx_overrun)
  );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 5;  // 10 unit clock
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // released on a falling edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* dv/tb_uart.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart testbench
// table of loopback and driven-line tests with result checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_uart
  import uart_pkg::*;
();

  localparam int NUM_TESTS  = 5;
  localparam int FRAME_CLKS = (DATA_BITS + 2) * CLKS_PER_BIT;
  localparam int WAIT_LIMIT = 3 * FRAME_CLKS;  // per wait, in clk cycles

  wire        clk;
  wire        rst_n;
  logic [7:0] in_data;
  logic       in_valid;
  wire        in_ready;
  wire        tx_line;
  wire        rx_line;
  wire  [7:0] rx_data;
  wire        rx_valid;
  logic       rx_ready;
  wire        tx_busy;
  wire        rx_frame_err;
  wire        rx_overrun;

  logic use_loop;  // 1 feeds tx_line back, 0 selects the driver
  logic drv_line;

  // stimulus table, byte 0 in bits [7:0], bytes past the eighth are random filler
  string       t_name  [NUM_TESTS] = '{"reset_single", "burst", "bit_timing",
                                       "framing_error", "overrun"};
  int          t_count [NUM_TESTS] = '{1, 10, 1, 2, 2};
  logic [63:0] t_bytes [NUM_TESTS] = '{64'h3c, 64'h8040_2010_0804_0201, 64'ha5,
                                       64'h4b96, 64'h7ec3};
  logic        t_loop  [NUM_TESTS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
  logic        t_stop  [NUM_TESTS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
  // rx_ready held low until every frame is in
  logic        t_hold  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

  logic [7:0]  exp_q [$];
  logic [31:0] rng;
  int          err_cnt;
  int          fail_cnt;
  int          stall_at;  // bytes accepted when in_ready first fell
  int          fe_cnt;
  int          ov_cnt;
  int          rx_got;

  clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  uart_top uut (.*);

  assign rx_line = use_loop ? tx_line : drv_line;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERROR %s: expected %0h, got %0h", sig, exp, got);
    err_cnt++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    err_cnt++;
  endtask

  // offers the queued bytes back to back on the valid/ready input
  task automatic push_bytes();
    int wait_cnt;
    int i;
    for (i = 0; i < exp_q.size(); i++) begin
      in_data  = exp_q[i];
      in_valid = 1'b1;
      wait_cnt = 0;
      while (!in_ready && wait_cnt < WAIT_LIMIT) begin
        if (stall_at < 0)
          stall_at = i;
        @(negedge clk);
        wait_cnt++;
      end
      if (!in_ready) begin
        report_timeout("in_ready");
        break;
      end
      @(negedge clk);  // taken on the rising edge in between
    end
    in_valid = 1'b0;
  endtask

  // bit-level line driver with a chosen stop bit
  task automatic drive_frames(input logic stop);
    logic [DATA_BITS+1:0] frame;
    int i;
    int b;
    for (i = 0; i < exp_q.size(); i++) begin
      frame = {stop, exp_q[i], 1'b0};  // start bit in bit 0
      for (b = 0; b < DATA_BITS + 3; b++) begin
        drv_line = (b < DATA_BITS + 2) ? frame[b] : 1'b1;  // last slot is an idle gap
        repeat (CLKS_PER_BIT) @(negedge clk);
      end
    end
  endtask

  // watches tx_line and tx_busy on every cycle of one frame
  task automatic check_frame(input logic [7:0] b);
    logic [DATA_BITS+2:0] frame;
    int   wait_cnt;
    int   c;
    logic bad;
    frame    = {2'b11, b, 1'b0};  // stop bit, then idle line
    wait_cnt = 0;
    bad      = 1'b0;
    while (tx_line !== 1'b0 && wait_cnt < WAIT_LIMIT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (tx_line !== 1'b0) begin
      report_timeout("start bit on tx_line");
    end else begin
      for (c = 0; c <= FRAME_CLKS && !bad; c++) begin
        if (tx_line !== frame[c / CLKS_PER_BIT]) begin
          report_mismatch($sformatf("tx_line, frame cycle %0d", c),
                          frame[c / CLKS_PER_BIT], tx_line);
          bad = 1'b1;
        end
        if (tx_busy !== (c < FRAME_CLKS)) begin
          report_mismatch($sformatf("tx_busy, frame cycle %0d", c), c < FRAME_CLKS, tx_busy);
          bad = 1'b1;
        end
        @(negedge clk);
      end
    end
  endtask

  // counts finished frames, a new valid byte or an overrun pulse each
  task automatic collect_rx(input logic hold);
    int   wait_cnt;
    int   events;
    int   got;
    logic prev_valid;
    wait_cnt   = 0;
    events     = 0;
    got        = 0;
    prev_valid = 1'b0;
    fe_cnt     = 0;
    ov_cnt     = 0;
    rx_ready   = !hold;
    while (events < exp_q.size() && wait_cnt < WAIT_LIMIT) begin
      @(negedge clk);
      wait_cnt++;
      if (rx_frame_err)
        fe_cnt++;
      if (rx_overrun || (rx_valid && !prev_valid)) begin
        ov_cnt   = ov_cnt + rx_overrun;
        events++;
        wait_cnt = 0;
      end
      if (rx_valid && rx_ready && got < exp_q.size()) begin
        if (rx_data !== exp_q[got])
          report_mismatch("rx_data", exp_q[got], rx_data);
        got++;
      end
      prev_valid = rx_valid;
    end
    if (events < exp_q.size()) begin
      report_timeout("received frame");
    end else if (hold) begin
      rx_ready = 1'b1;  // held byte goes on the next rising edge
      if (rx_valid !== 1'b1)
        report_mismatch("rx_valid", 1, rx_valid);
      if (rx_data !== exp_q[0])
        report_mismatch("rx_data", exp_q[0], rx_data);
      got++;
    end
    rx_got = got;
  endtask

  initial begin
    int t;
    int i;
    int wait_cnt;
    int err_before;
    int exp_got;
    int exp_fe;
    int exp_ov;
    int exp_stall;
    in_data  = 8'h00;
    in_valid = 1'b0;
    rx_ready = 1'b1;
    use_loop = 1'b1;
    drv_line = 1'b1;
    err_cnt  = 0;
    fail_cnt = 0;
    rng      = 32'd82;

    wait_cnt = 0;
    while (rst_n !== 1'b1 && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (rst_n !== 1'b1)
      report_timeout("reset release");

    for (t = 0; t < NUM_TESTS; t++) begin
      err_before = err_cnt;
      if (t == 0 && {tx_line, in_ready, tx_busy, rx_valid, rx_frame_err, rx_overrun} !== 6'h30)
        report_mismatch("{tx_line, in_ready, tx_busy, rx_valid, rx_frame_err, rx_overrun}",
                        6'h30, {tx_line, in_ready, tx_busy, rx_valid, rx_frame_err, rx_overrun});
      exp_q.delete();
      for (i = 0; i < t_count[t]; i++) begin
        if (i < 8) begin
          exp_q.push_back(t_bytes[t][8*i +: 8]);
        end else begin
          rng = xorshift(rng);
          exp_q.push_back(rng[7:0]);
        end
      end
      exp_got   = t_hold[t] ? 1 : t_count[t];  // later frames dropped while held
      exp_ov    = t_hold[t] ? t_count[t] - 1 : 0;
      exp_fe    = t_stop[t] ? 0 : t_count[t];
      // the head byte stays queued until its frame ends
      exp_stall = (t_loop[t] && t_count[t] > FIFO_DEPTH) ? FIFO_DEPTH : -1;
      use_loop  = t_loop[t];
      stall_at  = -1;

      fork
        collect_rx(t_hold[t]);
        if (t_loop[t])
          push_bytes();
        else
          drive_frames(t_stop[t]);
        if (t_loop[t])
          check_frame(exp_q[0]);
      join

      @(negedge clk);
      if (rx_valid !== 1'b0)
        report_mismatch("rx_valid", 0, rx_valid);  // nothing left behind
      if (rx_got != exp_got)
        report_mismatch("rx_valid handshakes", exp_got, rx_got);
      if (fe_cnt != exp_fe)
        report_mismatch("rx_frame_err pulses", exp_fe, fe_cnt);
      if (ov_cnt != exp_ov)
        report_mismatch("rx_overrun pulses", exp_ov, ov_cnt);
      if (stall_at != exp_stall)
        report_mismatch("in_ready low after bytes", exp_stall, stall_at);

      if (err_cnt == err_before) begin
        $display("test %0d %s: ok", t, t_name[t]);
      end else begin
        fail_cnt++;
        $display("test %0d %s: FAILED, %0d errors", t, t_name[t], err_cnt - err_before);
      end
    end

    $display("totals: %0d tests, %0d failed, %0d errors", NUM_TESTS, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hw/uart_pkg.sv
hw/tx_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
dv/clk_gen.sv
dv/tb_uart.sv
